//--- Bender.yml
package:
  name: pcs_scramble_link

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/pcs_block_pkg.sv
      - src/scrambler_pkg.sv
      - src/scrambler.sv
      - src/descrambler.sv
      - src/sync_header_monitor.sv
      - src/pcs_scramble_link.sv
  - target: test
    files:
      - tests/tb_pcs_scramble_link.sv

//--- src/descrambler.sv
`timescale 1ns/1ps

module descrambler
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_valid,
	input  logic                        i_bypass,
	input  logic                        i_tag,
	input  pcs_block_pkg::coded_block_t i_data,
	output pcs_block_pkg::coded_block_t o_data,
	output logic                        o_tag
);

	import pcs_block_pkg::*;
	import scrambler_pkg::*;

	scrambler_state_t state;
	scrambler_state_t state_next;
	coded_block_t     descrambled;
	coded_block_t     data_reg;
	logic             tag_reg;

	// received bits feed the history, so a slip heals after 58 bits
	always_comb
	begin
		state_next  = state;
		descrambled = i_data;
		for (int i = LEN_PAYLOAD-1; i >= 0; i--)
		begin
			descrambled[i] = i_data[i] ^ feedback(state_next);
			state_next     = shift_in(state_next, i_data[i]);
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			state <= SEED_STATE;
		else if (i_enable && !i_bypass)
			state <= state_next;
	end

	// header rides through untouched in both paths
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			data_reg <= '0;
		else if (i_enable)
		begin
			if (i_bypass)
				data_reg <= i_data;
			else
				data_reg <= descrambled;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			tag_reg <= 1'b0;
		else if (i_enable && i_valid)
			tag_reg <= i_tag;
	end

	assign o_data = data_reg;
	assign o_tag  = tag_reg;

	// outputs are clean right after reset
	a_reset_clears_output: assert property (@(posedge i_clock)
		i_reset |=> (o_data == '0) && (o_tag == 1'b0));

	// a stall freezes the history
	a_stall_holds_state: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_enable |=> $stable(state));

endmodule

//--- src/pcs_block_pkg.sv
`include "pcs_settings.svh"

package pcs_block_pkg;

	localparam int LEN_SYNC_HEADER = 2;
	localparam int LEN_PAYLOAD     = `PCS_LEN_CODED_BLOCK - LEN_SYNC_HEADER;

	// header sits in the top two bits, payload below it
	typedef logic [`PCS_LEN_CODED_BLOCK-1:0] coded_block_t;
	typedef logic [LEN_SYNC_HEADER-1:0] sync_header_t;
	typedef logic [`PCS_ERR_COUNT_WIDTH-1:0] err_count_t;

	localparam sync_header_t SH_DATA = 2'b01;
	localparam sync_header_t SH_CTRL = 2'b10;

	// control block, type 1E, all idle characters
	localparam coded_block_t IDLE_BLOCK = {SH_CTRL, 8'h1E, 56'h0};

	function automatic sync_header_t get_header(input coded_block_t block);
		return block[`PCS_LEN_CODED_BLOCK-1 -: LEN_SYNC_HEADER];
	endfunction

	// 00 and 11 never appear on a healthy link
	function automatic logic header_is_valid(input sync_header_t header);
		return (header == SH_DATA) || (header == SH_CTRL);
	endfunction

endpackage

//--- src/pcs_scramble_link.sv
`timescale 1ns/1ps

module pcs_scramble_link
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_tx_valid,
	input  logic                        i_tx_tag,
	input  pcs_block_pkg::coded_block_t i_tx_data,
	input  logic                        i_tx_bypass,
	input  logic                        i_rx_bypass,
	output pcs_block_pkg::coded_block_t o_rx_data,
	output logic                        o_rx_tag,
	output logic                        o_header_error,
	output pcs_block_pkg::err_count_t   o_header_error_count
);

	import pcs_block_pkg::*;

	// scrambled line between tx and rx
	coded_block_t scr_data;
	logic         scr_valid;
	logic         scr_tag;

	scrambler u_scrambler
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_valid  (i_tx_valid),
		.i_bypass (i_tx_bypass),
		.i_tag    (i_tx_tag),
		.i_data   (i_tx_data),
		.o_data   (scr_data),
		.o_valid  (scr_valid),
		.o_tag    (scr_tag)
	);

	descrambler u_descrambler
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_valid  (scr_valid),
		.i_bypass (i_rx_bypass),
		.i_tag    (scr_tag),
		.i_data   (scr_data),
		.o_data   (o_rx_data),
		.o_tag    (o_rx_tag)
	);

	// watches the line in parallel with the descrambler
	sync_header_monitor u_sync_header_monitor
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_valid        (scr_valid),
		.i_data         (scr_data),
		.o_header_error (o_header_error),
		.o_error_count  (o_header_error_count)
	);

endmodule

//--- src/pcs_settings.svh
`ifndef PCS_SETTINGS_SVH
`define PCS_SETTINGS_SVH

// 66-bit coded block, 2-bit sync header on top
`define PCS_LEN_CODED_BLOCK 66

// history length for 1 + x^39 + x^58
`define PCS_LEN_SCRAMBLER 58
`define PCS_SCRAMBLER_SEED 0

`define PCS_ERR_COUNT_WIDTH 16

`endif

//--- src/scrambler.sv
`timescale 1ns/1ps

module scrambler
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_valid,
	input  logic                        i_bypass,
	input  logic                        i_tag,
	input  pcs_block_pkg::coded_block_t i_data,
	output pcs_block_pkg::coded_block_t o_data,
	output logic                        o_valid,
	output logic                        o_tag
);

	import pcs_block_pkg::*;
	import scrambler_pkg::*;

	scrambler_state_t state;
	scrambler_state_t state_next;
	coded_block_t     scrambled;
	coded_block_t     data_reg;
	logic             valid_reg;
	logic             tag_reg;

	// msb first, scrambled bit feeds the history
	always_comb
	begin
		state_next = state;
		scrambled  = i_data;
		for (int i = LEN_PAYLOAD-1; i >= 0; i--)
		begin
			scrambled[i] = i_data[i] ^ feedback(state_next);
			state_next   = shift_in(state_next, scrambled[i]);
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			state <= SEED_STATE;
		else if (i_enable && !i_bypass)
			state <= state_next;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			data_reg  <= '0;
			valid_reg <= 1'b0;
		end
		else if (i_enable)
		begin
			data_reg  <= i_bypass ? i_data : scrambled;
			valid_reg <= i_valid;
		end
	end

	// tag follows valid blocks only
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			tag_reg <= 1'b0;
		else if (i_enable && i_valid)
			tag_reg <= i_tag;
	end

	assign o_data  = data_reg;
	assign o_valid = valid_reg;
	assign o_tag   = tag_reg;

	// bypassed block must leave the history untouched
	a_bypass_holds_state: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bypass |=> $stable(state));

endmodule

//--- src/scrambler_pkg.sv
`include "pcs_settings.svh"

package scrambler_pkg;

	localparam int LEN_STATE = `PCS_LEN_SCRAMBLER;

	// bit 0 holds the most recent bit
	typedef logic [LEN_STATE-1:0] scrambler_state_t;

	// x^58 and x^39 terms
	localparam int TAP_FAR  = 57;
	localparam int TAP_NEAR = 38;

	localparam scrambler_state_t SEED_STATE = scrambler_state_t'(`PCS_SCRAMBLER_SEED);

	function automatic logic feedback(input scrambler_state_t state);
		return state[TAP_FAR] ^ state[TAP_NEAR];
	endfunction

	function automatic scrambler_state_t shift_in(input scrambler_state_t state, input logic bit_in);
		return {state[LEN_STATE-2:0], bit_in};
	endfunction

endpackage

//--- src/sync_header_monitor.sv
`timescale 1ns/1ps

module sync_header_monitor
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_enable,
	input  logic                        i_valid,
	input  pcs_block_pkg::coded_block_t i_data,
	output logic                        o_header_error,
	output pcs_block_pkg::err_count_t   o_error_count
);

	import pcs_block_pkg::*;

	sync_header_t header;
	logic         header_bad;
	logic         error_reg;
	err_count_t   count_reg;

	// header is never scrambled, so it can be checked on the line
	assign header     = get_header(i_data);
	assign header_bad = i_valid && !header_is_valid(header);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			error_reg <= 1'b0;
			count_reg <= '0;
		end
		else if (i_enable)
		begin
			error_reg <= header_bad;
			// saturate instead of wrapping
			if (header_bad && (count_reg != '1))
				count_reg <= count_reg + 1'b1;
		end
	end

	assign o_header_error = error_reg;
	assign o_error_count  = count_reg;

	// only reset may bring the count down
	a_count_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
		1'b1 |=> (o_error_count >= $past(o_error_count)));

endmodule

//--- tests/pcs_link_tests.mem
// id enable valid tag tx_bypass rx_bypass tx_data expected_rx_data expected_rx_tag expected_count
// rx_bypass acts on the block of the line before, which reaches rx one cycle later
// from the zero seed, payload 8000000000000000 scrambles to 8000000001000020
01 1 1 1 1 0 18000000001000020 18000000000000000 1 0000
01 1 1 0 0 0 18000000000000000 18000000001000020 0 0000
01 1 1 1 0 1 10123456789abcdef 10123456789abcdef 1 0000
02 1 1 0 0 0 1fedcba9876543210 1fedcba9876543210 0 0000
02 1 1 1 0 0 21e00000000000000 21e00000000000000 1 0000
02 1 1 1 0 0 1ffffffffffffffff 1ffffffffffffffff 1 0000
02 1 1 0 0 0 2a5a5a5a5a5a5a5a5 2a5a5a5a5a5a5a5a5 0 0000
03 1 1 1 0 0 11111111111111111 11111111111111111 1 0000
03 1 0 0 0 0 12222222222222222 12222222222222222 1 0000
03 1 1 0 0 0 23333333333333333 23333333333333333 0 0000
03 1 0 1 0 0 14444444444444444 14444444444444444 0 0000
03 1 1 1 0 0 21e00000000000000 21e00000000000000 1 0000
04 1 1 0 0 0 15555555555555555 15555555555555555 0 0000
04 1 1 1 0 0 26666666666666666 26666666666666666 1 0000
04 0 1 0 0 0 3ffffffffffffffff 15555555555555555 0 0000
04 0 0 1 0 0 00000000000000000 15555555555555555 0 0000
04 1 1 0 0 0 17777777777777777 17777777777777777 0 0000
04 1 1 1 0 0 28888888888888888 28888888888888888 1 0000
05 1 1 0 0 0 00123456789abcdef 00123456789abcdef 0 0001
05 1 0 1 0 0 3fedcba9876543210 3fedcba9876543210 0 0001
05 1 1 0 0 0 3a5a5a5a5a5a5a5a5 3a5a5a5a5a5a5a5a5 0 0002
05 1 0 1 0 0 00f0f0f0f0f0f0f0f 00f0f0f0f0f0f0f0f 0 0002
05 1 1 1 0 0 10f0f0f0f0f0f0f0f 10f0f0f0f0f0f0f0f 1 0002
ff 0 0 0 0 0 0 0 0 0

//--- tests/tb_pcs_scramble_link.sv
`timescale 1ns/1ps

module tb_pcs_scramble_link;

	import pcs_block_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int LINE_WORDS   = 10;
	localparam int MAX_VECTORS  = 48;
	localparam int NUM_RANDOM   = 32;
	localparam int MAX_ENTRIES  = MAX_VECTORS + NUM_RANDOM;
	localparam int RANDOM_TEST  = 6;

	logic         i_clock;
	logic         i_reset;
	logic         i_enable;
	logic         i_tx_valid;
	logic         i_tx_tag;
	coded_block_t i_tx_data;
	logic         i_tx_bypass;
	logic         i_rx_bypass;
	coded_block_t o_rx_data;
	logic         o_rx_tag;
	logic         o_header_error;
	err_count_t   o_header_error_count;

	coded_block_t vec_mem [0:MAX_VECTORS*LINE_WORDS-1];

	// control bits are enable, valid, tag, tx bypass, rx bypass
	logic [4:0]   entry_ctrl      [0:MAX_ENTRIES-1];
	coded_block_t entry_data      [0:MAX_ENTRIES-1];
	coded_block_t entry_exp_data  [0:MAX_ENTRIES-1];
	logic         entry_exp_tag   [0:MAX_ENTRIES-1];
	err_count_t   entry_exp_count [0:MAX_ENTRIES-1];
	int           entry_test      [0:MAX_ENTRIES-1];
	// enabled edges until the block shows at o_rx_data, -1 when idle
	int           entry_wait      [0:MAX_ENTRIES-1];

	int     test_left   [0:RANDOM_TEST];
	int     test_errors [0:RANDOM_TEST];
	int     num_entries;
	int     num_pending;
	int     num_checks;
	int     num_errors;
	int     tests_passed;
	int     tests_failed;
	integer seed;
	logic   entries_ready;
	logic   last_exp_error;

	pcs_scramble_link DUT
	(
		.i_clock              (i_clock),
		.i_reset              (i_reset),
		.i_enable             (i_enable),
		.i_tx_valid           (i_tx_valid),
		.i_tx_tag             (i_tx_tag),
		.i_tx_data            (i_tx_data),
		.i_tx_bypass          (i_tx_bypass),
		.i_rx_bypass          (i_rx_bypass),
		.o_rx_data            (o_rx_data),
		.o_rx_tag             (o_rx_tag),
		.o_header_error       (o_header_error),
		.o_header_error_count (o_header_error_count)
	);

	initial
		i_clock = 1'b0;

	always #(CLOCK_PERIOD/2) i_clock = ~i_clock;

	task automatic record_result(input int test, input logic ok);
		num_checks++;
		if (!ok)
		begin
			num_errors++;
			test_errors[test]++;
		end
	endtask

	task automatic check_block(input string name, input coded_block_t expected,
		input coded_block_t actual, input int test);
		if (actual !== expected)
			$display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		record_result(test, actual === expected);
	endtask

	task automatic check_tag(input string name, input logic expected, input logic actual,
		input int test);
		if (actual !== expected)
			$display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
		record_result(test, actual === expected);
	endtask

	task automatic check_count(input string name, input err_count_t expected,
		input err_count_t actual, input int test);
		if (actual !== expected)
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
		record_result(test, actual === expected);
	endtask

	task automatic report_test(input int test);
		if (test_errors[test] == 0)
		begin
			tests_passed++;
			$display("test %0d passed", test);
		end
		else
		begin
			tests_failed++;
			$display("test %0d failed with %0d mismatches", test, test_errors[test]);
		end
	endtask

	task automatic add_entry(input int test, input logic [4:0] ctrl, input coded_block_t data,
		input coded_block_t exp_data, input logic exp_tag, input err_count_t exp_count);
		entry_test[num_entries]      = test;
		entry_ctrl[num_entries]      = ctrl;
		entry_data[num_entries]      = data;
		entry_exp_data[num_entries]  = exp_data;
		entry_exp_tag[num_entries]   = exp_tag;
		entry_exp_count[num_entries] = exp_count;
		entry_wait[num_entries]      = -1;
		test_left[test]++;
		num_entries++;
	endtask

	// ten words per line, a test id of ff ends the list
	task automatic load_vectors(output err_count_t final_count);
		int         base;
		logic [4:0] ctrl;
		final_count = '0;
		$readmemh("tests/pcs_link_tests.mem", vec_mem);
		for (int v = 0; v < MAX_VECTORS; v++)
		begin
			base = v * LINE_WORDS;
			if ($isunknown(vec_mem[base]) || vec_mem[base] == 'hff)
				break;
			for (int w = 1; w <= 5; w++)
				ctrl[5-w] = vec_mem[base+w][0];
			add_entry(int'(vec_mem[base]), ctrl, vec_mem[base+6], vec_mem[base+7],
				vec_mem[base+8][0], err_count_t'(vec_mem[base+9]));
			// count never falls, so the largest value is where the file leaves it
			if (err_count_t'(vec_mem[base+9]) > final_count)
				final_count = err_count_t'(vec_mem[base+9]);
		end
	endtask

	task automatic add_random_blocks(input err_count_t count);
		logic [31:0]  upper;
		logic [31:0]  lower;
		logic [31:0]  pick;
		sync_header_t header;
		for (int r = 0; r < NUM_RANDOM; r++)
		begin
			upper  = $random(seed);
			lower  = $random(seed);
			pick   = $random(seed);
			header = pick[1] ? SH_CTRL : SH_DATA;
			// round trip gives back the block that went in
			add_entry(RANDOM_TEST, {2'b11, pick[0], 2'b00}, {header, upper, lower},
				{header, upper, lower}, pick[0], count);
		end
	endtask

	task automatic drive_entry(input int k);
		{i_enable, i_tx_valid, i_tx_tag, i_tx_bypass, i_rx_bypass} = entry_ctrl[k];
		i_tx_data = entry_data[k];
		// stalled line is checked at the next falling edge
		entry_wait[k] = entry_ctrl[k][4] ? 2 : 0;
		num_pending++;
	endtask

	task automatic age_entries();
		for (int k = 0; k < num_entries; k++)
			if (entry_wait[k] > 0)
				entry_wait[k]--;
	endtask

	task automatic check_due_entries();
		int           test;
		sync_header_t header;
		for (int k = 0; k < num_entries; k++)
		begin
			if (entry_wait[k] == 0)
			begin
				test = entry_test[k];
				// valid 00 or 11 pulses the error, a stall keeps the last value
				if (entry_ctrl[k][4])
				begin
					header         = entry_data[k][$bits(coded_block_t)-1 -: 2];
					last_exp_error = entry_ctrl[k][3] &&
						((header == 2'b00) || (header == 2'b11));
				end
				check_block("o_rx_data", entry_exp_data[k], o_rx_data, test);
				check_tag("o_rx_tag", entry_exp_tag[k], o_rx_tag, test);
				check_tag("o_header_error", last_exp_error, o_header_error, test);
				check_count("o_header_error_count", entry_exp_count[k],
					o_header_error_count, test);
				entry_wait[k] = -1;
				num_pending--;
				test_left[test]--;
				if (test_left[test] == 0)
					report_test(test);
			end
		end
	endtask

	initial
	begin
		err_count_t final_count;
		i_reset        = 1'b1;
		i_enable       = 1'b0;
		i_tx_valid     = 1'b0;
		i_tx_tag       = 1'b0;
		i_tx_data      = '0;
		i_tx_bypass    = 1'b0;
		i_rx_bypass    = 1'b0;
		seed           = 32'hffe6;
		num_entries    = 0;
		num_pending    = 0;
		num_checks     = 0;
		num_errors     = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		entries_ready  = 1'b0;
		last_exp_error = 1'b0;
		for (int t = 0; t <= RANDOM_TEST; t++)
		begin
			test_left[t]   = 0;
			test_errors[t] = 0;
		end
		load_vectors(final_count);
		add_random_blocks(final_count);
		entries_ready = 1'b1;

		repeat (2) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		check_block("o_rx_data", '0, o_rx_data, 0);
		check_tag("o_rx_tag", 1'b0, o_rx_tag, 0);
		check_tag("o_header_error", 1'b0, o_header_error, 0);
		check_count("o_header_error_count", '0, o_header_error_count, 0);
		report_test(0);

		for (int k = 0; k < num_entries; k++)
		begin
			drive_entry(k);
			@(posedge i_clock);
			if (i_enable)
				age_entries();
			@(negedge i_clock);
			check_due_entries();
		end

		// invalid filler pushes the last blocks out
		i_enable    = 1'b1;
		i_tx_valid  = 1'b0;
		i_tx_bypass = 1'b0;
		i_rx_bypass = 1'b0;
		while (num_pending > 0)
		begin
			@(posedge i_clock);
			age_entries();
			@(negedge i_clock);
			check_due_entries();
		end

		$display("tests passed %0d, failed %0d, checks %0d, mismatches %0d",
			tests_passed, tests_failed, num_checks, num_errors);
		if (num_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		wait (entries_ready);
		#((num_entries + 20) * CLOCK_PERIOD);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("Errors found");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+src
src/pcs_block_pkg.sv
src/scrambler_pkg.sv
src/scrambler.sv
src/descrambler.sv
src/sync_header_monitor.sv
src/pcs_scramble_link.sv
tests/tb_pcs_scramble_link.sv
